// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lcdController
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) lcd_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== lcdBusIf.sv ====
`timescale 1ns/1ps

// One bus write request, sequencer to bus writer.
interface lcdBusIf;
    import lcd_pkg::*;

    logic        start; // One-cycle request.
    busKind      kind;  // Command, data or both.
    logic [15:0] cmd;   // Command word.
    logic [15:0] data;  // Data word.
    logic        done;  // One-cycle completion.

    // Request side.
    modport master (output start, output kind, output cmd, output data, input done);

    // Strobe generator side.
    modport writer (input start, input kind, input cmd, input data, output done);

endinterface

// ==== lcdBusWriter.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcdBusWriter (
    input  logic        clk,
    input  logic        rst_n,
    lcdBusIf.writer     bus,
    output logic        lcdCs,
    output logic        lcdRs,
    output logic        lcdWr,
    output logic        lcdRd,
    output logic [15:0] lcdData
);
    import lcd_pkg::*;

    localparam int WordCycles = `LCD_WR_LOW + `LCD_WR_HIGH;
    localparam int PhaseWidth = $clog2(WordCycles);
    localparam logic [PhaseWidth-1:0] LowEnd    = PhaseWidth'(`LCD_WR_LOW - 1);
    localparam logic [PhaseWidth-1:0] LastPhase = PhaseWidth'(WordCycles - 1);

    logic                  busy;
    logic [PhaseWidth-1:0] phase;    // Clock within the word.
    logic                  lastWord; // Word selector.
    logic [15:0]           pendData; // Second word of a command-plus-data.

    assign lcdRd = 1'b1; // No read-back.

    //////////////////////////////////////////////////
    // Strobe timing.
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            phase    <= '0;
            lastWord <= 1'b0;
            lcdCs    <= 1'b1;
            lcdRs    <= 1'b0;
            lcdWr    <= 1'b1;
            lcdData  <= 16'h0000;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (!busy) begin
                if (bus.start) begin // First word.
                    busy     <= 1'b1;
                    phase    <= '0;
                    lcdCs    <= 1'b0;
                    lcdWr    <= 1'b0;
                    lcdRs    <= (bus.kind == kindData);
                    lcdData  <= (bus.kind == kindData) ? bus.data : bus.cmd;
                    lastWord <= (bus.kind != kindCmdData);
                end
            end else begin
                phase <= phase + 1'b1;
                if (phase == LowEnd) lcdWr <= 1'b1; // Panel latches here.
                if (phase == LastPhase) begin
                    phase <= '0;
                    if (lastWord) begin // Release the bus.
                        busy     <= 1'b0;
                        lcdCs    <= 1'b1;
                        lcdRs    <= 1'b0;
                        lcdData  <= 16'h0000;
                        bus.done <= 1'b1;
                    end else begin // Data word follows.
                        lcdWr    <= 1'b0;
                        lcdRs    <= 1'b1;
                        lcdData  <= pendData;
                        lastWord <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && bus.start) pendData <= bus.data;
    end

    // Every strobe inside a chip select.
    wrInsideCs: assert property (@(posedge clk) disable iff (!rst_n) !lcdWr |-> !lcdCs)
        else $error("WR strobe with CS high");

endmodule

// ==== lcdController.sv ====
`timescale 1ns/1ps

module lcdController (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          en,
    input  lcd_pkg::lcdOp trigger,
    input  logic [15:0]   data1,
    input  logic [15:0]   data2,
    output logic          done,
    output logic          lcdRst,
    output logic          backlight,
    output logic          lcdCs,
    output logic          lcdRs,
    output logic          lcdWr,
    output logic          lcdRd,
    output logic [15:0]   lcdData
);

    lcdBusIf busIf (); // Sequencer to writer.

    logic        load;
    logic [15:0] loadValue;
    logic        expired;
    logic [2:0]  index;
    logic [15:0] regAddr;
    logic [15:0] regData;

    lcdSequencer lcdSequencer_inst (
        .clk(clk), .rst_n(rst_n), .en(en), .trigger(trigger),
        .data1(data1), .data2(data2), .done(done),
        .lcdRst(lcdRst), .backlight(backlight), .bus(busIf.master),
        .load(load), .loadValue(loadValue), .expired(expired),
        .index(index), .regAddr(regAddr), .regData(regData)
    );

    lcdDelayTimer lcdDelayTimer_inst (
        .clk(clk), .rst_n(rst_n), .load(load), .loadValue(loadValue), .expired(expired)
    );

    lcdInitRom lcdInitRom_inst (.index(index), .regAddr(regAddr), .regData(regData));

    // Panel pins.
    lcdBusWriter lcdBusWriter_inst (
        .clk(clk), .rst_n(rst_n), .bus(busIf.writer),
        .lcdCs(lcdCs), .lcdRs(lcdRs), .lcdWr(lcdWr), .lcdRd(lcdRd), .lcdData(lcdData)
    );

endmodule

// ==== lcdDelayTimer.sv ====
`timescale 1ns/1ps

module lcdDelayTimer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load,
    input  logic [15:0] loadValue,
    output logic        expired
);

    logic [15:0] count;
    logic        counting; // Run flag.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counting <= 1'b0;
        end else if (load) begin
            counting <= 1'b1;
        end else if (expired) begin
            counting <= 1'b0; // Stop after one pulse.
        end
    end

    // Down-count.
    always_ff @(posedge clk) begin
        if (load) count <= loadValue;
        else if (counting && count != 16'd0) count <= count - 16'd1;
    end

    assign expired = counting && (count == 16'd0); // One cycle.

    // Sequencer reloads only once a wait is over.
    noReload: assert property (@(posedge clk) disable iff (!rst_n) load |-> !counting)
        else $error("timer loaded while counting");

endmodule

// ==== lcdInitRom.sv ====
`timescale 1ns/1ps

module lcdInitRom (
    input  logic [2:0]  index,
    output logic [15:0] regAddr,
    output logic [15:0] regData
);

    // Register address and data pairs.
    always_comb begin
        case (index)
            3'd0: begin // First page unlock key.
                regAddr = 16'hF000;
                regData = 16'h0055;
            end
            3'd1: begin
                regAddr = 16'hF001;
                regData = 16'h00AA;
            end
            3'd2: begin
                regAddr = 16'hF002;
                regData = 16'h0052;
            end
            3'd3: begin
                regAddr = 16'hF003;
                regData = 16'h0008;
            end
            3'd4: begin // Page 1 select.
                regAddr = 16'hF004;
                regData = 16'h0001;
            end
            3'd5: begin // AVDD level.
                regAddr = 16'hB000;
                regData = 16'h000D;
            end
            3'd6: begin // AVDD ratio.
                regAddr = 16'hB600;
                regData = 16'h0034;
            end
            3'd7: begin // 16-bit pixels.
                regAddr = 16'h3A00;
                regData = 16'h0055;
            end
            default: begin
                regAddr = 16'h0000;
                regData = 16'h0000;
            end
        endcase
    end

endmodule

// ==== lcdSequencer.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcdSequencer (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          en,
    input  lcd_pkg::lcdOp trigger,
    input  logic [15:0]   data1,
    input  logic [15:0]   data2,
    output logic          done,
    output logic          lcdRst,
    output logic          backlight,
    lcdBusIf.master       bus,
    output logic          load,
    output logic [15:0]   loadValue,
    input  logic          expired,
    output logic [2:0]    index,
    input  logic [15:0]   regAddr,
    input  logic [15:0]   regData
);
    import lcd_pkg::*;

    localparam logic [3:0] InitDepth = 4'(`LCD_INIT_DEPTH);

    typedef enum logic [1:0] {sIdle, sIssue, sWait, sRelease} seqState;

    seqState     state;
    logic [3:0]  step;          // Step within the current operation.
    logic        actBus;        // This step is a bus write.
    logic        actDelay;      // This step is a timed wait.
    logic        actFinish;     // No step left.
    logic        actRst;        // Reset pin level during the wait.
    busKind      actKind;
    logic [15:0] actCmd;
    logic [15:0] actData;
    logic [15:0] actDelayValue;
    logic [7:0]  addrByte;      // Address byte for CASET/RASET.

    assign index = step[2:0]; // ROM entry follows the step.

    // Byte order XS[15:8], XS[7:0], XE[15:8], XE[7:0].
    assign addrByte = step[1] ? (step[0] ? data2[7:0] : data2[15:8])
                              : (step[0] ? data1[7:0] : data1[15:8]);

    //////////////////////////////////////////////////
    // Step decode.
    //////////////////////////////////////////////////
    always_comb begin
        actBus        = 1'b0;
        actDelay      = 1'b0;
        actRst        = 1'b1;
        actKind       = kindCmd;
        actCmd        = 16'h0000;
        actData       = 16'h0000;
        actDelayValue = 16'd0;
        case (trigger)
            opReset: begin
                if (step < 4'd2) begin
                    actDelay      = 1'b1;
                    actDelayValue = `LCD_RST_CYCLES;
                    actRst        = step[0]; // Low first, then high.
                end
            end
            opInit: begin
                if (step < InitDepth) begin // ROM pairs.
                    actBus  = 1'b1;
                    actKind = kindCmdData;
                    actCmd  = regAddr;
                    actData = regData;
                end else if (step == InitDepth) begin
                    actBus = 1'b1;
                    actCmd = `LCD_CMD_SLPOUT;
                end else if (step == InitDepth + 4'd1) begin // Sleep-out wait.
                    actDelay      = 1'b1;
                    actDelayValue = `LCD_SLEEP_CYCLES;
                end else if (step == InitDepth + 4'd2) begin
                    actBus = 1'b1;
                    actCmd = `LCD_CMD_DISPON;
                end else if (step == InitDepth + 4'd3) begin
                    actBus  = 1'b1;
                    actKind = kindCmdData;
                    actCmd  = `LCD_CMD_MADCTL;
                    actData = 16'h0000; // Default scan direction.
                end
            end
            opColumn, opPage: begin
                if (step < 4'd4) begin
                    actBus  = 1'b1;
                    actKind = kindCmdData;
                    actCmd  = ((trigger == opColumn) ? `LCD_CMD_CASET : `LCD_CMD_RASET)
                              + {14'd0, step[1:0]};
                    actData = {8'h00, addrByte};
                end
            end
            opGram: begin
                actBus = (step == 4'd0);
                actCmd = (data1 != 16'h0000) ? `LCD_CMD_RAMWR : `LCD_CMD_RAMRD;
            end
            opDisplay: begin
                actBus = (step == 4'd0);
                actCmd = (data1 != 16'h0000) ? `LCD_CMD_DISPON : `LCD_CMD_DISPOFF;
            end
            opData: begin
                actBus  = (step == 4'd0);
                actKind = kindData;
                actData = data1; // Pixel word.
            end
            default: ;
        endcase
    end

    assign actFinish = !actBus && !actDelay;

    //////////////////////////////////////////////////
    // Control FSM.
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= sIdle;
            step      <= 4'd0;
            done      <= 1'b0;
            bus.start <= 1'b0;
            load      <= 1'b0;
            lcdRst    <= 1'b1;
            backlight <= 1'b0;
        end else begin
            done      <= 1'b0; // Pulses by default.
            bus.start <= 1'b0;
            load      <= 1'b0;
            case (state)
                sIdle: begin
                    if (en) begin
                        step  <= 4'd0;
                        state <= sIssue;
                    end
                end
                sIssue: begin
                    if (actFinish) begin
                        done  <= 1'b1;
                        state <= sRelease;
                    end else begin
                        bus.start <= actBus;
                        load      <= actDelay;
                        state     <= sWait;
                    end
                    if (actDelay) lcdRst <= actRst;
                    if (trigger == opReset) backlight <= 1'b0; // Dark while in reset.
                    if (actFinish && trigger == opInit) backlight <= 1'b1;
                    if (actFinish && trigger == opDisplay) backlight <= (data1 != 16'h0000);
                end
                sWait: begin
                    if (bus.done || expired) begin
                        step  <= step + 4'd1;
                        state <= sIssue;
                    end
                end
                sRelease: if (!en) state <= sIdle; // Host drops en.
                default: state <= sIdle;
            endcase
        end
    end

    // Request payload, held until the next step.
    always_ff @(posedge clk) begin
        if (state == sIssue) begin
            bus.kind  <= actKind;
            bus.cmd   <= actCmd;
            bus.data  <= actData;
            loadValue <= actDelayValue;
        end
    end

    // No done pulse until the writer has answered.
    doneAfterWrite: assert property (@(posedge clk) disable iff (!rst_n)
        bus.start |-> !done until_with bus.done)
        else $error("done while a bus write is pending");

endmodule

// ==== lcd_consts.svh ====
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// Panel command words.
`define LCD_CMD_SLPOUT  16'h1100
`define LCD_CMD_DISPOFF 16'h2800
`define LCD_CMD_DISPON  16'h2900
`define LCD_CMD_MADCTL  16'h3600

// Address set bases, sub-address 0..3 in the low byte.
`define LCD_CMD_CASET   16'h2A00
`define LCD_CMD_RASET   16'h2B00

// GRAM access.
`define LCD_CMD_RAMWR   16'h2C00
`define LCD_CMD_RAMRD   16'h2E00

// Init ROM size in entries.
`define LCD_INIT_DEPTH  8

// WR strobe phases in clocks.
`define LCD_WR_LOW      2
`define LCD_WR_HIGH     2

// Delay lengths in clocks.
// Short values for simulation.
// Scale up for a real panel.
`define LCD_RST_CYCLES   16'd20
`define LCD_SLEEP_CYCLES 16'd30

`endif

// ==== lcd_pkg.sv ====
// Types shared by the TFT command controller.
package lcd_pkg;

    //////////////////////////////////////////////////
    // Host operation codes.
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        opIdle    = 4'd0, // Nothing to do, done at once.
        opReset   = 4'd1, // Hardware reset pulse.
        opInit    = 4'd2, // ROM registers, sleep-out, display on.
        opColumn  = 4'd3, // CASET, data1 start and data2 end.
        opPage    = 4'd4, // RASET, data1 start and data2 end.
        opGram    = 4'd5, // Nonzero data1 writes GRAM, zero reads.
        opDisplay = 4'd6, // Nonzero data1 on, zero off.
        opData    = 4'd7  // One pixel word from data1.
    } lcdOp;

    //////////////////////////////////////////////////
    // Bus write kinds.
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        kindCmd     = 2'd0, // Command word only, RS low.
        kindData    = 2'd1, // Data word only, RS high.
        kindCmdData = 2'd2  // Command word then data word.
    } busKind;

endpackage

// ==== sim.f ====
+incdir+.
lcd_pkg.sv
lcdBusIf.sv
lcdInitRom.sv
lcdDelayTimer.sv
lcdBusWriter.sv
lcdSequencer.sv
lcdController.sv
tb_lcdController.sv

// ==== tb_lcdController.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module tb_lcdController;
    import lcd_pkg::*;

    typedef struct packed {
        lcdOp        op;
        logic [15:0] d1;
        logic [15:0] d2;
        logic        rnd; // Operands from the LFSR.
    } stimEntry;

    localparam int NumOps = 14;
    localparam int WorstOpCycles = 2 * 12 * `LCD_INIT_DEPTH + int'(`LCD_SLEEP_CYCLES)
                                   + 2 * int'(`LCD_RST_CYCLES) + 64;
    localparam int WatchdogCycles = 16 + NumOps * WorstOpCycles;

    // Operation, data1, data2, random flag.
    localparam stimEntry StimTable [NumOps] = '{
        '{opIdle,    16'h0000, 16'h0000, 1'b0},
        '{opReset,   16'h0000, 16'h0000, 1'b0},
        '{opInit,    16'h0000, 16'h0000, 1'b0},
        '{opColumn,  16'h0000, 16'h0000, 1'b1},
        '{opPage,    16'h0000, 16'h0000, 1'b1},
        '{opColumn,  16'h0000, 16'h031F, 1'b0}, // Full 800 columns.
        '{opGram,    16'h0001, 16'h0000, 1'b0},
        '{opGram,    16'h0000, 16'h0000, 1'b0},
        '{opDisplay, 16'h0000, 16'h0000, 1'b0},
        '{opDisplay, 16'h8000, 16'h0000, 1'b0},
        '{opData,    16'h0000, 16'h0000, 1'b1},
        '{opData,    16'hF800, 16'h0000, 1'b0},
        '{opReset,   16'h0000, 16'h0000, 1'b0},
        '{opPage,    16'h0000, 16'h0000, 1'b1}
    };

    // Panel register table for the expected init words.
    logic [15:0] romAddr [8] = '{16'hF000, 16'hF001, 16'hF002, 16'hF003,
                                 16'hF004, 16'hB000, 16'hB600, 16'h3A00};
    logic [15:0] romData [8] = '{16'h0055, 16'h00AA, 16'h0052, 16'h0008,
                                 16'h0001, 16'h000D, 16'h0034, 16'h0055};

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        en = 1'b0;
    lcdOp        trigger = opIdle;
    logic [15:0] data1 = 16'h0000;
    logic [15:0] data2 = 16'h0000;
    logic        done, lcdRst, backlight, lcdCs, lcdRs, lcdWr, lcdRd;
    logic [15:0] lcdData;

    logic [31:0] lfsr = 32'h087aeb0a;
    logic [16:0] expWords [$];  // {rs, data}.
    logic [16:0] gotWords [$];
    int          gotCycles [$]; // Cycle of each WR rising edge.
    int          cycle = 0;
    int          doneCount = 0;
    int          rstLowRun = 0;
    int          rstLowMax = 0;
    logic        litInReset = 1'b0;
    logic        prevWr = 1'b1;

    always #5 clk = ~clk; // 100 MHz.

    lcdController lcdController_inst (
        .clk(clk), .rst_n(rst_n), .en(en), .trigger(trigger), .data1(data1), .data2(data2),
        .done(done), .lcdRst(lcdRst), .backlight(backlight), .lcdCs(lcdCs), .lcdRs(lcdRs),
        .lcdWr(lcdWr), .lcdRd(lcdRd), .lcdData(lcdData)
    );

    task automatic reportMismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "check failed");
    endtask

    // 32-bit Fibonacci LFSR with taps 32 22 2 1.
    function automatic logic [15:0] randomWord();
        logic [15:0] w;
        logic        fb;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            w    = {w[14:0], fb}; // One step per bit.
        end
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Expected bus words per operation.
    //////////////////////////////////////////////////
    function automatic void buildExpected(input lcdOp op, input logic [15:0] d1,
                                          input logic [15:0] d2);
        logic [15:0] base;
        logic [7:0]  addrBytes [4];
        expWords.delete();
        addrBytes = '{d1[15:8], d1[7:0], d2[15:8], d2[7:0]}; // Start then end.
        case (op)
            opInit: begin
                for (int i = 0; i < `LCD_INIT_DEPTH; i++) begin
                    expWords.push_back({1'b0, romAddr[i]});
                    expWords.push_back({1'b1, romData[i]});
                end
                expWords.push_back({1'b0, `LCD_CMD_SLPOUT});
                expWords.push_back({1'b0, `LCD_CMD_DISPON});
                expWords.push_back({1'b0, `LCD_CMD_MADCTL});
                expWords.push_back({1'b1, 16'h0000}); // Scan direction.
            end
            opColumn, opPage: begin
                base = (op == opColumn) ? `LCD_CMD_CASET : `LCD_CMD_RASET;
                for (int i = 0; i < 4; i++) begin
                    expWords.push_back({1'b0, base + 16'(i)});
                    expWords.push_back({1'b1, 8'h00, addrBytes[i]});
                end
            end
            opGram: expWords.push_back({1'b0, (d1 != 0) ? `LCD_CMD_RAMWR : `LCD_CMD_RAMRD});
            opDisplay: expWords.push_back({1'b0, (d1 != 0) ? `LCD_CMD_DISPON : `LCD_CMD_DISPOFF});
            opData: expWords.push_back({1'b1, d1}); // Pixel word with RS high.
            default: ; // Idle and reset write nothing.
        endcase
    endfunction

    task automatic checkIdleLevels(input string when);
        assert (!done && lcdCs && lcdWr && lcdRd && lcdRst && !backlight && lcdData == 0)
            else reportMismatch($sformatf("%s: outputs not inactive", when));
    endtask

    //////////////////////////////////////////////////
    // Bus monitor sampling mid-cycle.
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) begin
            assert (lcdWr || !lcdCs) else reportMismatch("WR strobe while CS high");
            if (lcdWr && !prevWr && !lcdCs) begin // Panel latch point.
                gotWords.push_back({lcdRs, lcdData});
                gotCycles.push_back(cycle);
            end
            if (done) doneCount++;
            rstLowRun = lcdRst ? 0 : rstLowRun + 1;
            if (rstLowRun > rstLowMax) rstLowMax = rstLowRun;
            if (!lcdRst && backlight) litInReset = 1'b1;
        end
        prevWr = lcdWr;
        cycle++;
    end

    task automatic checkOperation(input lcdOp op, input logic [15:0] d1, input logic blAtDone);
        assert (doneCount == 1)
            else reportMismatch($sformatf("%s: %0d done pulses", op.name(), doneCount));
        assert (gotWords.size() == expWords.size())
            else reportMismatch($sformatf("%s: %0d words, expected %0d", op.name(),
                                          gotWords.size(), expWords.size()));
        foreach (expWords[i])
            assert (gotWords[i] == expWords[i])
                else reportMismatch($sformatf("%s word %0d: rs=%b data=%h, expected rs=%b data=%h",
                    op.name(), i, gotWords[i][16], gotWords[i][15:0],
                    expWords[i][16], expWords[i][15:0]));
        case (op)
            opReset: begin
                assert (rstLowMax >= int'(`LCD_RST_CYCLES))
                    else reportMismatch($sformatf("reset low only %0d cycles", rstLowMax));
                assert (!litInReset) else reportMismatch("backlight on during panel reset");
                checkIdleLevels("after reset operation");
            end
            opInit: begin
                // SLPOUT is word 16 and DISPON word 17.
                assert (gotCycles[17] - gotCycles[16] >= int'(`LCD_SLEEP_CYCLES))
                    else reportMismatch("sleep-out wait too short");
                assert (blAtDone) else reportMismatch("backlight off after init");
            end
            opDisplay: assert (blAtDone == (d1 != 0))
                else reportMismatch($sformatf("backlight %b for data1 %h", blAtDone, d1));
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////
    // Main sequence.
    //////////////////////////////////////////////////
    initial begin
        stimEntry    entry;
        logic [15:0] d1;
        logic [15:0] d2;
        logic        blAtDone;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checkIdleLevels("after power-on reset");
        for (int n = 0; n < NumOps; n++) begin
            entry = StimTable[n];
            d1 = entry.rnd ? randomWord() : entry.d1;
            d2 = entry.rnd ? randomWord() : entry.d2;
            buildExpected(entry.op, d1, d2);
            @(posedge clk);
            en      <= 1'b1;
            trigger <= entry.op;
            data1   <= d1;
            data2   <= d2;
            gotWords.delete();
            gotCycles.delete();
            doneCount  = 0;
            rstLowMax  = 0;
            litInReset = 1'b0;
            do @(negedge clk); while (!done); // Until the done pulse.
            blAtDone = backlight;
            @(posedge clk);
            en <= 1'b0;
            repeat (4) @(posedge clk); // Room for a stray done.
            checkOperation(entry.op, d1, blAtDone);
        end
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Timeout: no finish within %0d clock cycles", WatchdogCycles);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule
